/* design/c16_mem_pkg.sv */
// Shared widths, CPU bus addresses and encodings of the C16/Plus-4 memory map
// Slot codes also index the ROM store, so SLOT_NONE has to stay the last entry
package c16_mem_pkg;

	////////////////////////////////////////////////////////////
	// Widths and data types
	////////////////////////////////////////////////////////////

	localparam int ADDR_W     = 16;
	localparam int ROM_ADDR_W = 14;

	typedef logic [7:0]        byte_t;
	typedef logic [ADDR_W-1:0] cpu_addr_t;

	// Six 16 KB ROM slots plus the code for no ROM at all
	typedef enum logic [2:0] {
		SLOT_KERNAL,
		SLOT_BASIC,
		SLOT_FUNC_LO,
		SLOT_FUNC_HI,
		SLOT_CART_LO,
		SLOT_CART_HI,
		SLOT_NONE
	} rom_slot_e;

	typedef enum logic {
		IMG_PRG,
		IMG_ROM
	} image_kind_e;

	////////////////////////////////////////////////////////////
	// Bus addresses
	////////////////////////////////////////////////////////////

	// Plus-4 bank register window $FDD0-$FDDF
	localparam logic [ADDR_W-5:0] BANK_REG_PAGE = 12'hFDD;
	// Page $FCxx always reads the kernal
	localparam logic [7:0]        KERNAL_PAGE   = 8'hFC;
	localparam byte_t             OPEN_BUS      = 8'hFF;

	// BASIC end pointers written after a PRG, low byte at even entries
	localparam int        PATCH_COUNT = 8;
	localparam cpu_addr_t PATCH_ADDR [PATCH_COUNT] = '{
		16'h002D, 16'h002E,
		16'h002F, 16'h0030,
		16'h0031, 16'h0032,
		16'h009D, 16'h009E
	};

endpackage

/* design/prg_loader.sv */
`timescale 1ns/100ps
// Images arrive one byte per handshake, dl_last_i marks the final byte of each image
// A PRG must start with its two-byte load address; ROM images over 16 KB wrap
module prg_loader (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 dl_valid_i,
	output logic                                 dl_ready_o,
	input  c16_mem_pkg::byte_t                   dl_data_i,
	input  logic                                 dl_last_i,
	input  c16_mem_pkg::image_kind_e             dl_kind_i,
	input  c16_mem_pkg::rom_slot_e               dl_slot_i,
	output logic                                 ram_we_o,
	output c16_mem_pkg::cpu_addr_t               ram_addr_o,
	output c16_mem_pkg::byte_t                   ram_data_o,
	output logic                                 rom_we_o,
	output c16_mem_pkg::rom_slot_e               rom_slot_o,
	output logic [c16_mem_pkg::ROM_ADDR_W-1:0]   rom_offset_o,
	output c16_mem_pkg::byte_t                   rom_data_o,
	output logic                                 cart_lo_o,
	output logic                                 cart_hi_o
);

	logic                                        take;
	logic                                        take_prg;
	logic                                        take_rom;
	logic                                        prg_data;
	logic [1:0]                                  hdr_cnt;
	logic [c16_mem_pkg::ROM_ADDR_W-1:0]          rom_off;
	logic                                        patch_active;
	logic [$clog2(c16_mem_pkg::PATCH_COUNT)-1:0] patch_idx;
	c16_mem_pkg::cpu_addr_t                      load_addr;

	assign take     = dl_valid_i && dl_ready_o;
	assign take_prg = take && (dl_kind_i == c16_mem_pkg::IMG_PRG);
	assign take_rom = take && (dl_kind_i == c16_mem_pkg::IMG_ROM);
	// Bytes after the two header bytes go to RAM
	assign prg_data = take_prg && (hdr_cnt == 2'd2);

	////////////////////////////////////////////////////////////
	// Control: counters, patch sequence, ready, cartridge flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_ready_o   <= 1'b0;
			ram_we_o     <= 1'b0;
			rom_we_o     <= 1'b0;
			hdr_cnt      <= 2'd0;
			rom_off      <= '0;
			patch_active <= 1'b0;
			patch_idx    <= '0;
			cart_lo_o    <= 1'b0;
			cart_hi_o    <= 1'b0;
		end else begin
			ram_we_o <= prg_data || patch_active;
			rom_we_o <= take_rom;

			// Counters restart with every new image
			if (take && dl_last_i) begin
				hdr_cnt <= 2'd0;
				rom_off <= '0;
			end else begin
				if (take_prg && hdr_cnt != 2'd2)
					hdr_cnt <= hdr_cnt + 1'b1;
				if (take_rom)
					rom_off <= rom_off + 1'b1;
			end

			if (take_rom && dl_slot_i == c16_mem_pkg::SLOT_CART_LO)
				cart_lo_o <= 1'b1;
			if (take_rom && dl_slot_i == c16_mem_pkg::SLOT_CART_HI)
				cart_hi_o <= 1'b1;

			// Ready stays low for one cycle per pointer write
			if (patch_active) begin
				if (int'(patch_idx) == c16_mem_pkg::PATCH_COUNT - 1) begin
					patch_active <= 1'b0;
					dl_ready_o   <= 1'b1;
				end else begin
					patch_idx <= patch_idx + 1'b1;
				end
			end else if (take_prg && dl_last_i) begin
				patch_active <= 1'b1;
				patch_idx    <= '0;
				dl_ready_o   <= 1'b0;
			end else begin
				dl_ready_o <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath: load address and write payloads
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (take_prg) begin
			if (hdr_cnt == 2'd0) begin
				load_addr[7:0] <= dl_data_i;
			end else if (hdr_cnt == 2'd1) begin
				load_addr[15:8] <= dl_data_i;
			end else begin
				ram_addr_o <= load_addr;
				ram_data_o <= dl_data_i;
				load_addr  <= load_addr + 1'b1;
			end
		end else if (take_rom) begin
			rom_slot_o   <= dl_slot_i;
			rom_offset_o <= rom_off;
			rom_data_o   <= dl_data_i;
		end else if (patch_active) begin
			// load_addr now holds the end address of the program
			ram_addr_o <= c16_mem_pkg::PATCH_ADDR[patch_idx];
			ram_data_o <= patch_idx[0] ? load_addr[15:8] : load_addr[7:0];
		end
	end

endmodule

/* design/rom_bank_select.sv */
`timescale 1ns/100ps
// Bank register writes count only in the Plus-4 model, which is sampled during reset
// Address and direction are taken while cs_io_n_i is low and applied on its release
module rom_bank_select (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    plus4_i,
	input  c16_mem_pkg::cpu_addr_t  cpu_addr_i,
	input  logic                    cpu_rnw_i,
	input  logic                    cs0_n_i,
	input  logic                    cs1_n_i,
	input  logic                    cs_io_n_i,
	input  logic                    cart_lo_i,
	input  logic                    cart_hi_i,
	output c16_mem_pkg::rom_slot_e  rom_slot_o
);

	logic                   model_plus4;
	logic                   io_low_q;
	c16_mem_pkg::cpu_addr_t io_addr_q;
	logic                   io_rnw_q;
	logic                   bank_wr;
	logic [1:0]             bank_lo;
	logic [1:0]             bank_hi;

	// Write access to $FDDx that ends on this cycle
	assign bank_wr = model_plus4 && io_low_q && cs_io_n_i && !io_rnw_q &&
		(io_addr_q[c16_mem_pkg::ADDR_W-1:4] == c16_mem_pkg::BANK_REG_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_plus4 <= plus4_i;
			io_low_q    <= 1'b0;
			bank_lo     <= 2'd0;
			bank_hi     <= 2'd0;
		end else begin
			io_low_q <= !cs_io_n_i;
			if (bank_wr) begin
				bank_lo <= io_addr_q[1:0];
				bank_hi <= io_addr_q[3:2];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!cs_io_n_i) begin
			io_addr_q <= cpu_addr_i;
			io_rnw_q  <= cpu_rnw_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Slot decode for the two ROM windows
	////////////////////////////////////////////////////////////

	always_comb begin
		rom_slot_o = c16_mem_pkg::SLOT_NONE;
		if (!cs0_n_i) begin
			case (bank_lo)
				2'd0: rom_slot_o = c16_mem_pkg::SLOT_BASIC;
				2'd1: if (cart_lo_i) rom_slot_o = c16_mem_pkg::SLOT_CART_LO;
				2'd2: rom_slot_o = c16_mem_pkg::SLOT_FUNC_LO;
				default: rom_slot_o = c16_mem_pkg::SLOT_NONE;
			endcase
		end else if (!cs1_n_i) begin
			if (cpu_addr_i[c16_mem_pkg::ADDR_W-1:c16_mem_pkg::ADDR_W-8] ==
				c16_mem_pkg::KERNAL_PAGE) begin
				rom_slot_o = c16_mem_pkg::SLOT_KERNAL;
			end else begin
				case (bank_hi)
					2'd0: rom_slot_o = c16_mem_pkg::SLOT_KERNAL;
					2'd1: if (cart_hi_i) rom_slot_o = c16_mem_pkg::SLOT_CART_HI;
					2'd2: rom_slot_o = c16_mem_pkg::SLOT_FUNC_HI;
					default: rom_slot_o = c16_mem_pkg::SLOT_NONE;
				endcase
			end
		end
	end

endmodule

/* design/rom_store.sv */
`timescale 1ns/100ps
// One cycle read latency; a read of SLOT_NONE returns open bus
// Contents are undefined until an image has been loaded into a slot
module rom_store (
	input  logic                               clk_sys,
	input  logic                               we_i,
	input  c16_mem_pkg::rom_slot_e             wr_slot_i,
	input  logic [c16_mem_pkg::ROM_ADDR_W-1:0] wr_offset_i,
	input  c16_mem_pkg::byte_t                 wr_data_i,
	input  c16_mem_pkg::rom_slot_e             rd_slot_i,
	input  logic [c16_mem_pkg::ROM_ADDR_W-1:0] rd_offset_i,
	output c16_mem_pkg::byte_t                 rd_data_o
);

	c16_mem_pkg::rom_slot_e rd_slot_q;
	c16_mem_pkg::byte_t     slot_q [int'(c16_mem_pkg::SLOT_NONE)];

	////////////////////////////////////////////////////////////
	// One 16 KB array per slot
	////////////////////////////////////////////////////////////

	for (genvar s = 0; s < int'(c16_mem_pkg::SLOT_NONE); s++) begin : g_slot
		c16_mem_pkg::byte_t mem [2**c16_mem_pkg::ROM_ADDR_W];

		always_ff @(posedge clk_sys) begin
			if (we_i && wr_slot_i == c16_mem_pkg::rom_slot_e'(s))
				mem[wr_offset_i] <= wr_data_i;
			slot_q[s] <= mem[rd_offset_i];
		end
	end

	// Slot number follows the array read by one cycle
	always_ff @(posedge clk_sys) begin
		rd_slot_q <= rd_slot_i;
	end

	always_comb begin
		rd_data_o = c16_mem_pkg::OPEN_BUS;
		for (int s = 0; s < int'(c16_mem_pkg::SLOT_NONE); s++) begin
			if (int'(rd_slot_q) == s)
				rd_data_o = slot_q[s];
		end
	end

endmodule

/* design/main_ram.sv */
`timescale 1ns/100ps
// CPU address, data and direction are captured while cs_ram_n_i is low
// A CPU write lands on the first edge after the select is released
module main_ram (
	input  logic                   clk_sys,
	input  logic                   ld_we_i,
	input  c16_mem_pkg::cpu_addr_t ld_addr_i,
	input  c16_mem_pkg::byte_t     ld_data_i,
	input  c16_mem_pkg::cpu_addr_t cpu_addr_i,
	input  logic                   cpu_rnw_i,
	input  c16_mem_pkg::byte_t     cpu_dout_i,
	input  logic                   cs_ram_n_i,
	output c16_mem_pkg::byte_t     rd_data_o
);

	c16_mem_pkg::byte_t     mem [2**c16_mem_pkg::ADDR_W];
	logic                   cs_low_q;
	c16_mem_pkg::cpu_addr_t hold_addr;
	c16_mem_pkg::byte_t     hold_data;
	logic                   hold_rnw;
	logic                   cpu_commit;

	// Rising edge of the RAM select after a write cycle
	assign cpu_commit = cs_low_q && cs_ram_n_i && !hold_rnw;

	always_ff @(posedge clk_sys) begin
		cs_low_q <= !cs_ram_n_i;
		if (!cs_ram_n_i) begin
			hold_addr <= cpu_addr_i;
			hold_data <= cpu_dout_i;
			hold_rnw  <= cpu_rnw_i;
		end
	end

	// CPU write wins if both ports hit the same byte
	always_ff @(posedge clk_sys) begin
		if (ld_we_i)
			mem[ld_addr_i] <= ld_data_i;
		if (cpu_commit)
			mem[hold_addr] <= hold_data;
		rd_data_o <= mem[cpu_addr_i];
	end

endmodule

/* design/cpu_read_mux.sv */
`timescale 1ns/100ps
// The source is registered on the same edge that the memories read on
// RAM takes priority when its select overlaps a ROM window
module cpu_read_mux (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cs_ram_n_i,
	input  c16_mem_pkg::rom_slot_e rom_slot_i,
	input  c16_mem_pkg::byte_t     ram_data_i,
	input  c16_mem_pkg::byte_t     rom_data_i,
	output c16_mem_pkg::byte_t     cpu_din_o
);

	logic ram_sel_q;
	logic rom_sel_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_sel_q <= 1'b0;
			rom_sel_q <= 1'b0;
		end else begin
			ram_sel_q <= !cs_ram_n_i;
			rom_sel_q <= cs_ram_n_i && (rom_slot_i != c16_mem_pkg::SLOT_NONE);
		end
	end

	// Nothing selected leaves the bus floating high
	always_comb begin
		if (ram_sel_q)
			cpu_din_o = ram_data_i;
		else if (rom_sel_q)
			cpu_din_o = rom_data_i;
		else
			cpu_din_o = c16_mem_pkg::OPEN_BUS;
	end

endmodule

/* design/c16_memory_map.sv */
`timescale 1ns/100ps
// Memory side of the C16/Plus-4: download loader, ROM banking, RAM and read bus
// CPU selects are active low and carry no handshake; reads return one cycle later
module c16_memory_map (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     plus4_i,
	input  logic                     dl_valid_i,
	output logic                     dl_ready_o,
	input  c16_mem_pkg::byte_t       dl_data_i,
	input  logic                     dl_last_i,
	input  c16_mem_pkg::image_kind_e dl_kind_i,
	input  c16_mem_pkg::rom_slot_e   dl_slot_i,
	input  c16_mem_pkg::cpu_addr_t   cpu_addr_i,
	input  logic                     cpu_rnw_i,
	input  c16_mem_pkg::byte_t       cpu_dout_i,
	input  logic                     cs_ram_n_i,
	input  logic                     cs0_n_i,
	input  logic                     cs1_n_i,
	input  logic                     cs_io_n_i,
	output c16_mem_pkg::byte_t       cpu_din_o
);

	// Loader write ports
	logic                               ld_ram_we;
	c16_mem_pkg::cpu_addr_t             ld_ram_addr;
	c16_mem_pkg::byte_t                 ld_ram_data;
	logic                               ld_rom_we;
	c16_mem_pkg::rom_slot_e             ld_rom_slot;
	logic [c16_mem_pkg::ROM_ADDR_W-1:0] ld_rom_offset;
	c16_mem_pkg::byte_t                 ld_rom_data;
	logic                               cart_lo;
	logic                               cart_hi;

	// CPU read side
	c16_mem_pkg::rom_slot_e             cpu_rom_slot;
	c16_mem_pkg::byte_t                 ram_q;
	c16_mem_pkg::byte_t                 rom_q;

	////////////////////////////////////////////////////////////
	// Download path
	////////////////////////////////////////////////////////////

	prg_loader prg_loader_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_valid_i   (dl_valid_i),
		.dl_ready_o   (dl_ready_o),
		.dl_data_i    (dl_data_i),
		.dl_last_i    (dl_last_i),
		.dl_kind_i    (dl_kind_i),
		.dl_slot_i    (dl_slot_i),
		.ram_we_o     (ld_ram_we),
		.ram_addr_o   (ld_ram_addr),
		.ram_data_o   (ld_ram_data),
		.rom_we_o     (ld_rom_we),
		.rom_slot_o   (ld_rom_slot),
		.rom_offset_o (ld_rom_offset),
		.rom_data_o   (ld_rom_data),
		.cart_lo_o    (cart_lo),
		.cart_hi_o    (cart_hi)
	);

	////////////////////////////////////////////////////////////
	// CPU bank decode, memories and read bus
	////////////////////////////////////////////////////////////

	rom_bank_select rom_bank_select_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.plus4_i    (plus4_i),
		.cpu_addr_i (cpu_addr_i),
		.cpu_rnw_i  (cpu_rnw_i),
		.cs0_n_i    (cs0_n_i),
		.cs1_n_i    (cs1_n_i),
		.cs_io_n_i  (cs_io_n_i),
		.cart_lo_i  (cart_lo),
		.cart_hi_i  (cart_hi),
		.rom_slot_o (cpu_rom_slot)
	);

	rom_store rom_store_i (
		.clk_sys     (clk_sys),
		.we_i        (ld_rom_we),
		.wr_slot_i   (ld_rom_slot),
		.wr_offset_i (ld_rom_offset),
		.wr_data_i   (ld_rom_data),
		.rd_slot_i   (cpu_rom_slot),
		.rd_offset_i (cpu_addr_i[c16_mem_pkg::ROM_ADDR_W-1:0]),
		.rd_data_o   (rom_q)
	);

	main_ram main_ram_i (
		.clk_sys    (clk_sys),
		.ld_we_i    (ld_ram_we),
		.ld_addr_i  (ld_ram_addr),
		.ld_data_i  (ld_ram_data),
		.cpu_addr_i (cpu_addr_i),
		.cpu_rnw_i  (cpu_rnw_i),
		.cpu_dout_i (cpu_dout_i),
		.cs_ram_n_i (cs_ram_n_i),
		.rd_data_o  (ram_q)
	);

	cpu_read_mux cpu_read_mux_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cs_ram_n_i (cs_ram_n_i),
		.rom_slot_i (cpu_rom_slot),
		.ram_data_i (ram_q),
		.rom_data_i (rom_q),
		.cpu_din_o  (cpu_din_o)
	);

endmodule

/* tests/c16_memory_map_checker.sv */
`timescale 1ns/100ps
// Bound into c16_memory_map, where it also sees the loader strobes and cartridge flags
// fail_cnt counts failed assertions for the testbench's final verdict
module c16_memory_map_checker (
	input logic                     clk_sys,
	input logic                     reset,
	input logic                     dl_valid_i,
	input logic                     dl_ready_i,
	input logic                     dl_last_i,
	input c16_mem_pkg::image_kind_e dl_kind_i,
	input logic                     cs_ram_n_i,
	input logic                     cs0_n_i,
	input logic                     cs1_n_i,
	input c16_mem_pkg::byte_t       cpu_din_i,
	input logic                     ld_ram_we_i,
	input logic                     ld_rom_we_i,
	input logic                     cart_lo_i,
	input logic                     cart_hi_i
);

	int fail_cnt = 0;

	// One stall cycle per pointer write after the last PRG byte
	patch_stall_a: assert property (@(posedge clk_sys) disable iff (reset)
		dl_valid_i && dl_ready_i && dl_last_i && dl_kind_i == c16_mem_pkg::IMG_PRG
		|=> !dl_ready_i [*c16_mem_pkg::PATCH_COUNT] ##1 dl_ready_i)
	else begin
		fail_cnt++;
		$error("dl_ready_o did not stall for exactly the pointer patch");
	end

	ready_after_reset_a: assert property (@(posedge clk_sys) $fell(reset) |=> dl_ready_i)
	else begin
		fail_cnt++;
		$error("dl_ready_o not high one cycle after reset release");
	end

	reset_state_a: assert property (@(posedge clk_sys)
		reset |=> !ld_ram_we_i && !ld_rom_we_i && !cart_lo_i && !cart_hi_i)
	else begin
		fail_cnt++;
		$error("write strobes or cartridge flags not clear after reset");
	end

	// Idle bus floats high
	open_bus_a: assert property (@(posedge clk_sys) disable iff (reset)
		cs_ram_n_i && cs0_n_i && cs1_n_i |=> cpu_din_i == c16_mem_pkg::OPEN_BUS)
	else begin
		fail_cnt++;
		$error("cpu_din_o not open bus after a cycle with no select");
	end

endmodule

bind c16_memory_map c16_memory_map_checker map_checker_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.dl_valid_i  (dl_valid_i),
	.dl_ready_i  (dl_ready_o),
	.dl_last_i   (dl_last_i),
	.dl_kind_i   (dl_kind_i),
	.cs_ram_n_i  (cs_ram_n_i),
	.cs0_n_i     (cs0_n_i),
	.cs1_n_i     (cs1_n_i),
	.cpu_din_i   (cpu_din_o),
	.ld_ram_we_i (ld_ram_we),
	.ld_rom_we_i (ld_rom_we),
	.cart_lo_i   (cart_lo),
	.cart_hi_i   (cart_hi)
);

/* tests/c16_memory_map_tb.sv */
`timescale 1ns/100ps
// ROM images are 16 bytes long, except the kernal, which has to reach page $FC
// Only bytes that were loaded or written are read back and checked
module c16_memory_map_tb;

	localparam int ROM_LEN         = 16;
	localparam int KERNAL_LEN      = 'h3C00 + ROM_LEN;
	localparam int PRG_LEN         = 48;
	localparam int WATCHDOG_CYCLES = 2 * (KERNAL_LEN + 5 * ROM_LEN + 4 * PRG_LEN) + 2000;
	localparam int SEL_RAM         = 0;
	localparam int SEL_CS0         = 1;
	localparam int SEL_CS1         = 2;

	logic                     clk_sys;
	logic                     reset;
	logic                     plus4_i;
	logic                     dl_valid_i;
	logic                     dl_ready_o;
	c16_mem_pkg::byte_t       dl_data_i;
	logic                     dl_last_i;
	c16_mem_pkg::image_kind_e dl_kind_i;
	c16_mem_pkg::rom_slot_e   dl_slot_i;
	c16_mem_pkg::cpu_addr_t   cpu_addr_i;
	logic                     cpu_rnw_i;
	c16_mem_pkg::byte_t       cpu_dout_i;
	logic                     cs_ram_n_i;
	logic                     cs0_n_i;
	logic                     cs1_n_i;
	logic                     cs_io_n_i;
	c16_mem_pkg::byte_t       cpu_din_o;

	// Reference model of RAM and of the ROM slots
	c16_mem_pkg::byte_t ref_ram [2**c16_mem_pkg::ADDR_W];
	c16_mem_pkg::byte_t ref_rom [int'(c16_mem_pkg::SLOT_NONE)][2**c16_mem_pkg::ROM_ADDR_W];
	logic [31:0]        rng_state = 32'h08ae_b80e;
	int                 checks    = 0;
	int                 errors    = 0;

	c16_memory_map c16_memory_map_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, stimulus did not finish", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_byte(input string name, input c16_mem_pkg::byte_t exp,
		input c16_mem_pkg::byte_t act);
		checks++;
		assert (act === exp)
		else begin
			errors++;
			$display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
		end
	endtask

	// Every call leaves the time 2 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic apply_reset(input logic model);
		reset   = 1'b1;
		plus4_i = model;
		repeat (4) @(posedge clk_sys);
		#2;
		reset = 1'b0;
	endtask

	task automatic send_byte(input c16_mem_pkg::byte_t data, input logic last,
		input c16_mem_pkg::image_kind_e kind, input c16_mem_pkg::rom_slot_e slot);
		dl_valid_i = 1'b1;
		dl_data_i  = data;
		dl_last_i  = last;
		dl_kind_i  = kind;
		dl_slot_i  = slot;
		// Ready is registered, its value now is what the next edge sees
		while (!dl_ready_o)
			idle(1);
		idle(1);
		dl_valid_i = 1'b0;
		dl_last_i  = 1'b0;
	endtask

	task automatic load_rom(input c16_mem_pkg::rom_slot_e slot, input int len);
		logic [31:0] r;
		for (int i = 0; i < len; i++) begin
			r = next_random();
			ref_rom[int'(slot)][i] = r[7:0];
			send_byte(r[7:0], i == len - 1, c16_mem_pkg::IMG_ROM, slot);
		end
	endtask

	task automatic load_prg(input c16_mem_pkg::cpu_addr_t addr, input int len);
		logic [31:0]            r;
		c16_mem_pkg::cpu_addr_t end_addr;
		send_byte(addr[7:0], 1'b0, c16_mem_pkg::IMG_PRG, c16_mem_pkg::SLOT_NONE);
		send_byte(addr[15:8], 1'b0, c16_mem_pkg::IMG_PRG, c16_mem_pkg::SLOT_NONE);
		for (int i = 0; i < len; i++) begin
			r = next_random();
			// Occasional gap of up to three cycles without valid
			if (r[9:8] == 2'd0)
				idle(int'(r[11:10]));
			ref_ram[addr + c16_mem_pkg::cpu_addr_t'(i)] = r[7:0];
			send_byte(r[7:0], i == len - 1, c16_mem_pkg::IMG_PRG, c16_mem_pkg::SLOT_NONE);
		end
		end_addr = addr + c16_mem_pkg::cpu_addr_t'(len);
		for (int k = 0; k < c16_mem_pkg::PATCH_COUNT; k++)
			ref_ram[c16_mem_pkg::PATCH_ADDR[k]] = (k % 2) ? end_addr[15:8] : end_addr[7:0];
		while (!dl_ready_o)
			idle(1);
		idle(1);
	endtask

	task automatic cpu_read(input c16_mem_pkg::cpu_addr_t addr, input int sel,
		input c16_mem_pkg::byte_t exp);
		cpu_addr_i = addr;
		cpu_rnw_i  = 1'b1;
		cs_ram_n_i = (sel != SEL_RAM);
		cs0_n_i    = (sel != SEL_CS0);
		cs1_n_i    = (sel != SEL_CS1);
		idle(1);
		cs_ram_n_i = 1'b1;
		cs0_n_i    = 1'b1;
		cs1_n_i    = 1'b1;
		check_byte("cpu_din_o", exp, cpu_din_o);
	endtask

	task automatic cpu_write(input c16_mem_pkg::cpu_addr_t addr, input c16_mem_pkg::byte_t data);
		cpu_addr_i = addr;
		cpu_dout_i = data;
		cpu_rnw_i  = 1'b0;
		cs_ram_n_i = 1'b0;
		idle(1);
		cs_ram_n_i = 1'b1;
		cpu_rnw_i  = 1'b1;
		idle(1);
		ref_ram[addr] = data;
	endtask

	task automatic bank_write(input logic [3:0] nibble);
		cpu_addr_i = {c16_mem_pkg::BANK_REG_PAGE, nibble};
		cpu_rnw_i  = 1'b0;
		cs_io_n_i  = 1'b0;
		idle(1);
		cs_io_n_i = 1'b1;
		cpu_rnw_i = 1'b1;
		idle(1);
	endtask

	// SLOT_NONE as the expected slot means open bus
	task automatic read_window(input int sel, input c16_mem_pkg::cpu_addr_t base, input int off,
		input c16_mem_pkg::rom_slot_e slot);
		c16_mem_pkg::byte_t exp;
		for (int i = 0; i < ROM_LEN; i++) begin
			exp = (slot == c16_mem_pkg::SLOT_NONE) ? c16_mem_pkg::OPEN_BUS :
				ref_rom[int'(slot)][off + i];
			cpu_read(base + c16_mem_pkg::cpu_addr_t'(i), sel, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0]            r;
		c16_mem_pkg::cpu_addr_t prg_addr;
		c16_mem_pkg::cpu_addr_t wr_addr [8];
		int                     assert_fails;
		reset      = 1'b1;
		plus4_i    = 1'b1;
		dl_valid_i = 1'b0;
		dl_data_i  = '0;
		dl_last_i  = 1'b0;
		dl_kind_i  = c16_mem_pkg::IMG_PRG;
		dl_slot_i  = c16_mem_pkg::SLOT_KERNAL;
		cpu_addr_i = '0;
		cpu_rnw_i  = 1'b1;
		cpu_dout_i = '0;
		cs_ram_n_i = 1'b1;
		cs0_n_i    = 1'b1;
		cs1_n_i    = 1'b1;
		cs_io_n_i  = 1'b1;
		apply_reset(1'b1);

		// PRG image and BASIC end pointers
		r = next_random();
		prg_addr = 16'h1000 + {4'h0, r[11:0]};
		load_prg(prg_addr, PRG_LEN);
		for (int i = 0; i < PRG_LEN; i++)
			cpu_read(prg_addr + 16'(i), SEL_RAM, ref_ram[prg_addr + 16'(i)]);
		for (int k = 0; k < c16_mem_pkg::PATCH_COUNT; k++)
			cpu_read(c16_mem_pkg::PATCH_ADDR[k], SEL_RAM, ref_ram[c16_mem_pkg::PATCH_ADDR[k]]);

		// System ROMs with both banks at 0
		load_rom(c16_mem_pkg::SLOT_KERNAL, KERNAL_LEN);
		load_rom(c16_mem_pkg::SLOT_BASIC, ROM_LEN);
		load_rom(c16_mem_pkg::SLOT_FUNC_LO, ROM_LEN);
		load_rom(c16_mem_pkg::SLOT_FUNC_HI, ROM_LEN);
		read_window(SEL_CS0, 16'h8000, 0, c16_mem_pkg::SLOT_BASIC);
		read_window(SEL_CS1, 16'hC000, 0, c16_mem_pkg::SLOT_KERNAL);

		// Cartridge banks before and after the cartridge images arrive
		bank_write(4'h5);
		read_window(SEL_CS0, 16'h8000, 0, c16_mem_pkg::SLOT_NONE);
		read_window(SEL_CS1, 16'hC000, 0, c16_mem_pkg::SLOT_NONE);
		read_window(SEL_CS1, {c16_mem_pkg::KERNAL_PAGE, 8'h00}, 'h3C00, c16_mem_pkg::SLOT_KERNAL);
		load_rom(c16_mem_pkg::SLOT_CART_LO, ROM_LEN);
		load_rom(c16_mem_pkg::SLOT_CART_HI, ROM_LEN);
		read_window(SEL_CS0, 16'h8000, 0, c16_mem_pkg::SLOT_CART_LO);
		read_window(SEL_CS1, 16'hC000, 0, c16_mem_pkg::SLOT_CART_HI);
		bank_write(4'hA);
		read_window(SEL_CS0, 16'h8000, 0, c16_mem_pkg::SLOT_FUNC_LO);
		read_window(SEL_CS1, 16'hC000, 0, c16_mem_pkg::SLOT_FUNC_HI);
		bank_write(4'hF);
		read_window(SEL_CS0, 16'h8000, 0, c16_mem_pkg::SLOT_NONE);
		read_window(SEL_CS1, 16'hC000, 0, c16_mem_pkg::SLOT_NONE);
		read_window(SEL_CS1, {c16_mem_pkg::KERNAL_PAGE, 8'h00}, 'h3C00, c16_mem_pkg::SLOT_KERNAL);

		// CPU writes to RAM
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			wr_addr[i] = {4'h2, r[19:8]};
			cpu_write(wr_addr[i], r[7:0]);
		end
		for (int i = 0; i < 8; i++)
			cpu_read(wr_addr[i], SEL_RAM, ref_ram[wr_addr[i]]);

		// C16 model ignores the bank register
		apply_reset(1'b0);
		bank_write(4'hA);
		read_window(SEL_CS0, 16'h8000, 0, c16_mem_pkg::SLOT_BASIC);
		read_window(SEL_CS1, 16'hC000, 0, c16_mem_pkg::SLOT_KERNAL);
		idle(2);

		assert_fails = c16_memory_map_i.map_checker_i.fail_cnt;
		$display("Checks %0d, value errors %0d, assertion failures %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* c16_memory_map.f */
design/c16_mem_pkg.sv
design/prg_loader.sv
design/rom_bank_select.sv
design/rom_store.sv
design/main_ram.sv
design/cpu_read_mux.sv
design/c16_memory_map.sv
tests/c16_memory_map_checker.sv
tests/c16_memory_map_tb.sv
